//--- hw/dft_consts.svh
`ifndef DFT_CONSTS_SVH
`define DFT_CONSTS_SVH

// width of one real or imaginary part at the stage input and output
`define DFT_SAMPLE_W 16

// width of a part after scaling, before the butterflies
`define DFT_MID_W 15

// twiddle parts are signed with 8 fraction bits, so 256 stands for 1.0
`define DFT_TW_W 10

// right shift applied to a twiddle product, with truncation
`define DFT_TW_SHIFT 10

// even groups are divided by four
`define DFT_EVEN_SHIFT 2

// complex samples per group and groups per block
`define DFT_LANES 4
`define DFT_GROUPS 8

// credits held by the upstream after reset, also the output FIFO depth
`define DFT_IN_CREDITS 4

// credits the stage holds towards the sink after reset
`define DFT_OUT_CREDITS 4

`endif

//--- hw/dft_pkg.sv
`include "dft_consts.svh"

package dft_pkg;

    // one complex sample as it enters or leaves the stage
    typedef struct packed {
        logic signed [`DFT_SAMPLE_W-1:0] re;
        logic signed [`DFT_SAMPLE_W-1:0] im;
    } cplx_in_t;

    // one complex sample after the twiddle multiply or the even shift
    typedef struct packed {
        logic signed [`DFT_MID_W-1:0] re;
        logic signed [`DFT_MID_W-1:0] im;
    } cplx_mid_t;

    // one twiddle factor
    typedef struct packed {
        logic signed [`DFT_TW_W-1:0] re;
        logic signed [`DFT_TW_W-1:0] im;
    } cplx_tw_t;

    // a beat on the input side, lane k at index k
    typedef cplx_in_t [`DFT_LANES-1:0] group_in_t;

    // a scaled group between the scaler and the butterflies
    typedef cplx_mid_t [`DFT_LANES-1:0] group_mid_t;

    // twiddle factor k multiplies lane k of an odd group
    typedef cplx_tw_t [`DFT_LANES-1:0] twiddle_set_t;

    // butterfly results, sum0 and sum1 pair lanes 0/2 and 1/3
    typedef struct packed {
        cplx_in_t sum0;
        cplx_in_t sum1;
        cplx_in_t diff0;
        cplx_in_t diff1;
    } group_out_t;

endpackage

//--- hw/dft_twiddle_cmul.sv
`timescale 1ns/10ps
`include "dft_consts.svh"

module dft_twiddle_cmul (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  dft_pkg::cplx_in_t sample_i,
    input  dft_pkg::cplx_tw_t twiddle_i,
    output dft_pkg::cplx_mid_t product_o
);

    localparam int PROD_W = `DFT_SAMPLE_W + `DFT_TW_W;

    logic signed [PROD_W-1:0] prod_rr;
    logic signed [PROD_W-1:0] prod_ii;
    logic signed [PROD_W-1:0] prod_ri;
    logic signed [PROD_W-1:0] prod_ir;
    // one extra bit holds the add or subtract of two full products
    logic signed [PROD_W:0]   acc_re;
    logic signed [PROD_W:0]   acc_im;
    logic signed [PROD_W:0]   shr_re;
    logic signed [PROD_W:0]   shr_im;

    assign prod_rr = sample_i.re * twiddle_i.re;
    assign prod_ii = sample_i.im * twiddle_i.im;
    assign prod_ri = sample_i.re * twiddle_i.im;
    assign prod_ir = sample_i.im * twiddle_i.re;

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    assign acc_re = prod_rr - prod_ii;
    assign acc_im = prod_ri + prod_ir;

    // arithmetic shift rounds towards minus infinity
    assign shr_re = acc_re >>> `DFT_TW_SHIFT;
    assign shr_im = acc_im >>> `DFT_TW_SHIFT;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            product_o <= '0;
        end else if (en_i) begin
            // only the low bits are kept, the upper ones are dropped
            product_o.re <= shr_re[`DFT_MID_W-1:0];
            product_o.im <= shr_im[`DFT_MID_W-1:0];
        end
    end

endmodule

//--- hw/dft_group_scaler.sv
`timescale 1ns/10ps
`include "dft_consts.svh"

module dft_group_scaler (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    input  dft_pkg::group_in_t    in_group_i,
    input  dft_pkg::twiddle_set_t twiddles_i,
    output logic                  mid_valid_o,
    output dft_pkg::group_mid_t   mid_group_o
);

    localparam int CNT_W = $clog2(`DFT_GROUPS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DFT_GROUPS - 1);

    logic [CNT_W-1:0]   group_cnt_q;
    logic               odd_group;
    logic               odd_sel_q;
    logic               tw_en;
    dft_pkg::cplx_mid_t tw_prod [`DFT_LANES];
    dft_pkg::cplx_mid_t even_q  [`DFT_LANES];

    // groups b, d, f and h of a block carry the twiddles
    assign odd_group = group_cnt_q[0];
    assign tw_en     = in_valid_i & odd_group;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            group_cnt_q <= '0;
            odd_sel_q   <= 1'b0;
            mid_valid_o <= 1'b0;
        end else begin
            mid_valid_o <= in_valid_i;
            if (in_valid_i) begin
                odd_sel_q   <= odd_group;
                group_cnt_q <= (group_cnt_q == CNT_LAST) ? '0 : group_cnt_q + 1'b1;
            end
        end
    end

    for (genvar lane = 0; lane < `DFT_LANES; lane++) begin : g_lane
        logic signed [`DFT_SAMPLE_W-1:0] shr_re;
        logic signed [`DFT_SAMPLE_W-1:0] shr_im;

        dft_twiddle_cmul i_cmul (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .en_i      (tw_en),
            .sample_i  (in_group_i[lane]),
            .twiddle_i (twiddles_i[lane]),
            .product_o (tw_prod[lane])
        );

        // after the shift the value fits in the narrower scaled width
        assign shr_re = in_group_i[lane].re >>> `DFT_EVEN_SHIFT;
        assign shr_im = in_group_i[lane].im >>> `DFT_EVEN_SHIFT;

        always_ff @(posedge clk_i) begin
            if (in_valid_i && !odd_group) begin
                even_q[lane].re <= shr_re[`DFT_MID_W-1:0];
                even_q[lane].im <= shr_im[`DFT_MID_W-1:0];
            end
        end
    end

    // both paths are one register deep, the parity picks the live one
    always_comb begin
        for (int lane = 0; lane < `DFT_LANES; lane++) begin
            mid_group_o[lane] = odd_sel_q ? tw_prod[lane] : even_q[lane];
        end
    end

    a_mid_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(mid_valid_o)
    ) else $error("mid_valid_o is unknown");

endmodule

//--- hw/dft_butterfly.sv
`timescale 1ns/10ps
`include "dft_consts.svh"

module dft_butterfly (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                mid_valid_i,
    input  dft_pkg::group_mid_t mid_group_i,
    output logic                bf_valid_o,
    output dft_pkg::group_out_t bf_group_o
);

    localparam int PAIRS = `DFT_LANES / 2;

    dft_pkg::cplx_in_t sum_c  [PAIRS];
    dft_pkg::cplx_in_t diff_c [PAIRS];

    // lane p pairs with lane p + 2, the widened parts cannot overflow
    always_comb begin
        logic signed [`DFT_SAMPLE_W-1:0] a_re;
        logic signed [`DFT_SAMPLE_W-1:0] a_im;
        logic signed [`DFT_SAMPLE_W-1:0] b_re;
        logic signed [`DFT_SAMPLE_W-1:0] b_im;

        for (int p = 0; p < PAIRS; p++) begin
            a_re = mid_group_i[p].re;
            a_im = mid_group_i[p].im;
            b_re = mid_group_i[p + PAIRS].re;
            b_im = mid_group_i[p + PAIRS].im;

            sum_c[p].re  = a_re + b_re;
            sum_c[p].im  = a_im + b_im;
            diff_c[p].re = a_re - b_re;
            diff_c[p].im = a_im - b_im;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bf_valid_o <= 1'b0;
        end else begin
            bf_valid_o <= mid_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mid_valid_i) begin
            bf_group_o.sum0  <= sum_c[0];
            bf_group_o.sum1  <= sum_c[1];
            bf_group_o.diff0 <= diff_c[0];
            bf_group_o.diff1 <= diff_c[1];
        end
    end

endmodule

//--- hw/dft_credit_buffer.sv
`timescale 1ns/10ps
`include "dft_consts.svh"

module dft_credit_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                wr_valid_i,
    input  dft_pkg::group_out_t wr_group_i,
    input  logic                out_credit_i,
    output logic                out_valid_o,
    output dft_pkg::group_out_t out_group_o,
    output logic                in_credit_o
);

    localparam int DEPTH  = `DFT_IN_CREDITS;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int FILL_W = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`DFT_OUT_CREDITS + 1);

    localparam logic [PTR_W-1:0]  PTR_LAST  = PTR_W'(DEPTH - 1);
    localparam logic [FILL_W-1:0] FILL_MAX  = FILL_W'(DEPTH);
    localparam logic [CRED_W-1:0] CRED_INIT = CRED_W'(`DFT_OUT_CREDITS);

    dft_pkg::group_out_t mem_q [DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [FILL_W-1:0] fill_q;
    logic [CRED_W-1:0] credit_cnt_q;
    logic              fifo_empty;
    logic              fifo_full;
    logic              pop;

    assign fifo_empty = (fill_q == '0);
    assign fifo_full  = (fill_q == FILL_MAX);

    // a beat leaves whenever there is data and the sink has room for it
    assign pop         = !fifo_empty && (credit_cnt_q != '0);
    assign out_valid_o = pop;
    assign out_group_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            mem_q[wr_ptr_q] <= wr_group_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            fill_q       <= '0;
            credit_cnt_q <= CRED_INIT;
            in_credit_o  <= 1'b0;
        end else begin
            // every freed slot goes back upstream as one credit
            in_credit_o <= pop;

            if (wr_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end

            case ({wr_valid_i, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase

            // a credit returned now is spendable from the next cycle on
            case ({out_credit_i, pop})
                2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    // the upstream credit count must keep the pipeline from overrunning the FIFO
    a_no_write_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wr_valid_i |-> !fifo_full
    ) else $error("write into a full output FIFO");

    a_credit_bound: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) credit_cnt_q <= CRED_INIT
    ) else $error("sink returned more credits than it was given");

endmodule

//--- hw/dft_stage.sv
`timescale 1ns/10ps

module dft_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    input  dft_pkg::group_in_t    in_group_i,
    input  dft_pkg::twiddle_set_t twiddles_i,
    output logic                  in_credit_o,
    output logic                  out_valid_o,
    output dft_pkg::group_out_t   out_group_o,
    input  logic                  out_credit_i
);

    // scaler to butterflies
    logic                mid_valid;
    dft_pkg::group_mid_t mid_group;

    // butterflies to the output FIFO
    logic                bf_valid;
    dft_pkg::group_out_t bf_group;

    dft_group_scaler i_scaler (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_group_i  (in_group_i),
        .twiddles_i  (twiddles_i),
        .mid_valid_o (mid_valid),
        .mid_group_o (mid_group)
    );

    dft_butterfly i_butterfly (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mid_valid_i (mid_valid),
        .mid_group_i (mid_group),
        .bf_valid_o  (bf_valid),
        .bf_group_o  (bf_group)
    );

    // holds finished groups while the sink is out of credits
    dft_credit_buffer i_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wr_valid_i   (bf_valid),
        .wr_group_i   (bf_group),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_group_o  (out_group_o),
        .in_credit_o  (in_credit_o)
    );

endmodule

//--- verif/tb_dft_stage.sv
`timescale 1ns/10ps
`include "dft_consts.svh"

module tb_dft_stage;

    localparam int CLK_HALF      = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_RESETS    = 5;
    localparam int TOTAL_BEATS   = 82;
    localparam int WATCHDOG_CYC  = TOTAL_BEATS * 20 + NUM_RESETS * RESET_CYCLES;
    localparam int HOLD_BEATS    = 12;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  in_valid_i;
    dft_pkg::group_in_t    in_group_i;
    dft_pkg::twiddle_set_t twiddles_i;
    logic                  in_credit_o;
    logic                  out_valid_o;
    dft_pkg::group_out_t   out_group_o;
    logic                  out_credit_i;

    // stimulus waiting for an input credit, and results waiting for the DUT
    dft_pkg::group_in_t    stim_grp_q [$];
    dft_pkg::twiddle_set_t stim_tw_q  [$];
    dft_pkg::group_out_t   exp_q      [$];

    dft_pkg::group_in_t    drv_grp;
    dft_pkg::twiddle_set_t drv_tw;
    dft_pkg::group_out_t   mon_exp;

    int    in_credits;
    int    grp_idx;
    int    out_owed;
    bit    sink_release;
    string test_name;
    int    test_errors;
    int    test_beats;
    int    credit_pulses;
    int    checks;
    int    total_errors;
    int    tests_passed;
    int    tests_failed;

    dft_stage i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_group_i   (in_group_i),
        .twiddles_i   (twiddles_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_group_o  (out_group_o),
        .out_credit_i (out_credit_i)
    );

    always #CLK_HALF clk_i = ~clk_i;

    // expected stage output, built from the scaling and butterfly rules
    function automatic dft_pkg::group_out_t ref_group(
        input dft_pkg::group_in_t g, input int idx, input dft_pkg::twiddle_set_t tw
    );
        int                          re_m [`DFT_LANES];
        int                          im_m [`DFT_LANES];
        int                          a;
        int                          b;
        int                          c;
        int                          d;
        int                          pr;
        int                          pi;
        logic signed [`DFT_MID_W-1:0] m_re;
        logic signed [`DFT_MID_W-1:0] m_im;
        dft_pkg::group_out_t         r;

        for (int k = 0; k < `DFT_LANES; k++) begin
            a = g[k].re;
            b = g[k].im;
            if (idx % 2 == 1) begin
                c = tw[k].re;
                d = tw[k].im;
                pr = (a * c - b * d) >>> `DFT_TW_SHIFT;
                pi = (a * d + b * c) >>> `DFT_TW_SHIFT;
            end else begin
                pr = a >>> `DFT_EVEN_SHIFT;
                pi = b >>> `DFT_EVEN_SHIFT;
            end
            // the scaled value keeps only its low bits
            m_re = pr[`DFT_MID_W-1:0];
            m_im = pi[`DFT_MID_W-1:0];
            re_m[k] = m_re;
            im_m[k] = m_im;
        end
        r.sum0.re  = 16'(re_m[0] + re_m[2]);
        r.sum0.im  = 16'(im_m[0] + im_m[2]);
        r.sum1.re  = 16'(re_m[1] + re_m[3]);
        r.sum1.im  = 16'(im_m[1] + im_m[3]);
        r.diff0.re = 16'(re_m[0] - re_m[2]);
        r.diff0.im = 16'(im_m[0] - im_m[2]);
        r.diff1.re = 16'(re_m[1] - re_m[3]);
        r.diff1.im = 16'(im_m[1] - im_m[3]);
        return r;
    endfunction

    function automatic dft_pkg::cplx_in_t make_cplx(input int re, input int im);
        dft_pkg::cplx_in_t s;

        s.re = re[`DFT_SAMPLE_W-1:0];
        s.im = im[`DFT_SAMPLE_W-1:0];
        return s;
    endfunction

    function automatic dft_pkg::cplx_tw_t make_tw(input int re, input int im);
        dft_pkg::cplx_tw_t t;

        t.re = re[`DFT_TW_W-1:0];
        t.im = im[`DFT_TW_W-1:0];
        return t;
    endfunction

    function automatic dft_pkg::group_in_t rand_group();
        dft_pkg::group_in_t g;

        for (int k = 0; k < `DFT_LANES; k++) begin
            g[k] = make_cplx($urandom(), $urandom());
        end
        return g;
    endfunction

    function automatic dft_pkg::twiddle_set_t rand_twiddles();
        dft_pkg::twiddle_set_t tw;

        for (int k = 0; k < `DFT_LANES; k++) begin
            tw[k] = make_tw($urandom(), $urandom());
        end
        return tw;
    endfunction

    task automatic check_group(input dft_pkg::group_out_t exp, input dft_pkg::group_out_t act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic push_group(input dft_pkg::group_in_t g, input dft_pkg::twiddle_set_t tw);
        stim_grp_q.push_back(g);
        stim_tw_q.push_back(tw);
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rst_n_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        // the upstream and sink bookkeeping restarts together with the DUT
        in_credits = `DFT_IN_CREDITS;
        grp_idx    = 0;
        out_owed   = 0;
        exp_q.delete();
        rst_n_i <= 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_errors   = 0;
        test_beats    = 0;
        credit_pulses = 0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;

        waited = 0;
        while ((stim_grp_q.size() != 0 || exp_q.size() != 0) && waited < limit) begin
            @(negedge clk_i);
            waited++;
        end
        if (stim_grp_q.size() != 0 || exp_q.size() != 0) begin
            $display("test %s: expected output groups did not arrive within %0d cycles",
                     test_name, limit);
            test_errors++;
        end
        // trailing credit returns settle before the next test
        repeat (4) @(negedge clk_i);
    endtask

    // polled on the rising edge, so the beat count from the falling edge has settled
    task automatic wait_beats(input int count, input int limit);
        int waited;

        waited = 0;
        while (test_beats < count && waited < limit) begin
            @(posedge clk_i);
            waited++;
        end
        if (test_beats < count) begin
            $display("test %s: only %0d of %0d output beats arrived within %0d cycles",
                     test_name, test_beats, count, limit);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed, %0d beats", test_name, test_beats);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
        total_errors += test_errors;
    endtask

    // upstream driver, one group per available input credit
    always @(posedge clk_i) begin
        if (rst_n_i && in_credits > 0 && stim_grp_q.size() > 0) begin
            drv_grp = stim_grp_q.pop_front();
            drv_tw  = stim_tw_q.pop_front();
            exp_q.push_back(ref_group(drv_grp, grp_idx, drv_tw));
            grp_idx = (grp_idx + 1) % `DFT_GROUPS;
            in_credits--;
            in_valid_i <= 1'b1;
            in_group_i <= drv_grp;
            twiddles_i <= drv_tw;
        end else begin
            in_valid_i <= 1'b0;
        end
    end

    // sink hands back one credit per consumed beat while released
    always @(posedge clk_i) begin
        if (rst_n_i && sink_release && out_owed > 0) begin
            out_credit_i <= 1'b1;
            out_owed--;
        end else begin
            out_credit_i <= 1'b0;
        end
    end

    // outputs are sampled mid-cycle where they are settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (in_credit_o) begin
                in_credits++;
                credit_pulses++;
            end
            if (out_valid_o) begin
                test_beats++;
                out_owed++;
                if (exp_q.size() == 0) begin
                    $display("test %s: output beat arrived with no group expected", test_name);
                    test_errors++;
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_group(mon_exp, out_group_o);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_i);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYC, test_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        dft_pkg::group_in_t    g;
        dft_pkg::twiddle_set_t tw;

        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        in_valid_i   = 1'b0;
        in_group_i   = '0;
        twiddles_i   = '0;
        out_credit_i = 1'b0;
        sink_release = 1'b1;
        in_credits   = `DFT_IN_CREDITS;
        grp_idx      = 0;
        out_owed     = 0;
        checks       = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "reset";
        void'($urandom(32'h817d));

        apply_reset();

        start_test("even_scaling");
        g[0] = make_cplx(-32768, -32768);
        g[1] = make_cplx(32767, -1);
        g[2] = make_cplx(-32768, 32767);
        g[3] = make_cplx(-5, 3);
        push_group(g, rand_twiddles());
        wait_drain(40);
        check_count("beats", 1, test_beats);
        finish_test();

        // the group counter now points at an odd group
        start_test("twiddle_multiply");
        g[0] = make_cplx(1000, -2000);
        g[1] = make_cplx(-32768, 12345);
        g[2] = make_cplx(32767, 32767);
        g[3] = make_cplx(-32768, -32768);
        tw[0] = make_tw(256, 0);
        tw[1] = make_tw(-181, 181);
        tw[2] = make_tw(0, -256);
        tw[3] = make_tw(-512, 511);
        push_group(g, tw);
        wait_drain(40);
        check_count("beats", 1, test_beats);
        finish_test();

        apply_reset();
        start_test("block_ordering");
        for (int i = 0; i < 8 * `DFT_GROUPS; i++) begin
            push_group(rand_group(), rand_twiddles());
        end
        wait_drain(64 * 10);
        check_count("beats", 8 * `DFT_GROUPS, test_beats);
        finish_test();

        apply_reset();
        start_test("back_pressure");
        sink_release = 1'b0;
        for (int i = 0; i < HOLD_BEATS; i++) begin
            push_group(rand_group(), rand_twiddles());
        end
        repeat (40) @(negedge clk_i);
        check_count("beats while held", `DFT_OUT_CREDITS, test_beats);
        check_count("input credits while held", `DFT_OUT_CREDITS, credit_pulses);
        check_count("groups stalled upstream",
                    HOLD_BEATS - `DFT_IN_CREDITS - `DFT_OUT_CREDITS, stim_grp_q.size());
        check_count("out_valid_o while held", 0, out_valid_o);
        sink_release = 1'b1;
        wait_drain(HOLD_BEATS * 10);
        check_count("beats after release", HOLD_BEATS, test_beats);
        finish_test();

        apply_reset();
        start_test("reset_mid_block");
        for (int i = 0; i < 3; i++) begin
            push_group(rand_group(), rand_twiddles());
        end
        // reset hits while a credit pulse is out and the third group enters the FIFO
        wait_beats(1, 40);
        apply_reset();
        check_count("beats before reset", 2, test_beats);
        @(negedge clk_i);
        check_count("out_valid_o after reset", 0, out_valid_o);
        check_count("in_credit_o after reset", 0, in_credit_o);
        // the first group after reset must be scaled as an even group
        push_group(rand_group(), rand_twiddles());
        push_group(rand_group(), rand_twiddles());
        wait_drain(40);
        check_count("beats", 4, test_beats);
        finish_test();

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, checks, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
hw/dft_pkg.sv
hw/dft_twiddle_cmul.sv
hw/dft_group_scaler.sv
hw/dft_butterfly.sv
hw/dft_credit_buffer.sv
hw/dft_stage.sv
verif/tb_dft_stage.sv

//--- Bender.yml
package:
  name: dft_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/dft_pkg.sv
      - hw/dft_twiddle_cmul.sv
      - hw/dft_group_scaler.sv
      - hw/dft_butterfly.sv
      - hw/dft_credit_buffer.sv
      - hw/dft_stage.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/tb_dft_stage.sv
